//--- common/atari_input_params.svh
//==========================================================================
// Sizes and limits of the controller front end. The widths follow the
// host word layout and must not change on their own. The mouse step
// limit and the stick threshold are in raw host counts.
//==========================================================================
`ifndef ATARI_INPUT_PARAMS_SVH
`define ATARI_INPUT_PARAMS_SVH

// Number of host controllers, one paddle channel each
`define PADDLE_PORTS 4

// Host word widths
`define JOY_WIDTH 16
`define ANALOG_WIDTH 16
`define POT_WIDTH 8
`define MOUSE_PKT_WIDTH 25
`define MOUSE_DELTA_WIDTH 9

// Largest mouse movement applied per packet, either direction
`define MOUSE_STEP_MAX 10

// Analog deflection needed to pick an axis
`define STICK_THRESHOLD 100

`endif

//--- common/atari_input_pkg.sv
//==========================================================================
// Types shared by the controller front end. Deltas and positions are
// two's complement. The mouse packet layout is the host's, with bit 24
// toggling once per new packet.
//==========================================================================
`include "atari_input_params.svh"

package atari_input_pkg;

	// Digital joystick word, bits 3..0 are up, down, left, right
	typedef logic [`JOY_WIDTH-1:0] joy_word_t;

	// Signed X in the low byte, signed Y in the high byte
	typedef logic [`ANALOG_WIDTH-1:0] analog_word_t;

	typedef logic [`POT_WIDTH-1:0] pot_t;
	typedef logic [`MOUSE_PKT_WIDTH-1:0] mouse_pkt_t;
	typedef logic signed [`MOUSE_DELTA_WIDTH-1:0] mouse_delta_t;
	typedef logic signed [`MOUSE_DELTA_WIDTH-1:0] mouse_pos_t;

	// Where a paddle channel takes its position from
	typedef enum logic [1:0] {
		pot_src_paddle,
		pot_src_stick,
		pot_src_mouse
	} pot_source_e;

	// Button positions in the joystick word
	localparam int joy_bit_fire   = 4;
	localparam int joy_bit_stick  = 5;
	localparam int joy_bit_paddle = 6;
	localparam int joy_bit_start  = 7;
	localparam int joy_bit_select = 8;
	localparam int joy_bit_pause  = 9;
	localparam int joy_bit_fire2  = 10;

endpackage

//--- common/paddle_in_if.sv
//==========================================================================
// Inputs of one paddle channel, already registered by the decoder.
// mouse_stb is a single-cycle pulse with no back-pressure, and the
// deltas are only meaningful while it is high.
//==========================================================================
`timescale 1ns/1ps

interface paddle_in_if;
	import atari_input_pkg::*;

	logic         stick_btn;
	logic         paddle_btn;
	analog_word_t joy_a;
	pot_t         paddle;
	logic         mouse_stb;
	mouse_delta_t mouse_dx;
	mouse_delta_t mouse_dy;
	// Bit 0 left, bit 1 right
	logic [1:0]   mouse_btn;

	modport src (
		output stick_btn, paddle_btn, joy_a, paddle,
		output mouse_stb, mouse_dx, mouse_dy, mouse_btn
	);

	modport dst (
		input stick_btn, paddle_btn, joy_a, paddle,
		input mouse_stb, mouse_dx, mouse_dy, mouse_btn
	);

endinterface

//--- hdl/host_input_decode.sv
//==========================================================================
// Registers the host controller words and decodes the mouse packet.
// Every output is one cycle behind its input. Only channel 0 sees the
// mouse. A packet that toggles on back-to-back cycles strobes each cycle.
//==========================================================================
`timescale 1ns/1ps
`include "atari_input_params.svh"

module host_input_decode (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  atari_input_pkg::joy_word_t    joystick_0,
	input  atari_input_pkg::joy_word_t    joystick_1,
	input  atari_input_pkg::joy_word_t    joystick_2,
	input  atari_input_pkg::joy_word_t    joystick_3,
	input  atari_input_pkg::analog_word_t joystick_analog_0,
	input  atari_input_pkg::analog_word_t joystick_analog_1,
	input  atari_input_pkg::analog_word_t joystick_analog_2,
	input  atari_input_pkg::analog_word_t joystick_analog_3,
	input  atari_input_pkg::pot_t         paddle_0,
	input  atari_input_pkg::pot_t         paddle_1,
	input  atari_input_pkg::pot_t         paddle_2,
	input  atari_input_pkg::pot_t         paddle_3,
	input  atari_input_pkg::mouse_pkt_t   ps2_mouse,
	paddle_in_if.src                      ch [`PADDLE_PORTS],
	output atari_input_pkg::joy_word_t    joy_q [`PADDLE_PORTS]
);
	import atari_input_pkg::*;

	localparam mouse_delta_t step_max = `MOUSE_STEP_MAX;
	localparam mouse_delta_t step_min = -`MOUSE_STEP_MAX;

	joy_word_t    joy_in [`PADDLE_PORTS];
	analog_word_t analog_in [`PADDLE_PORTS];
	pot_t         paddle_in [`PADDLE_PORTS];

	logic         mouse_toggle_q;
	logic         mouse_stb_q;
	mouse_delta_t mouse_dx_q;
	mouse_delta_t mouse_dy_q;
	logic [1:0]   mouse_btn_q;

	// Sign-extend a 7-bit movement and limit it to one step
	function automatic mouse_delta_t clamp_step(input logic sign, input logic [6:0] mag);
		mouse_delta_t raw;
		raw = {sign, sign, mag};
		if (raw > step_max)
			return step_max;
		if (raw < step_min)
			return step_min;
		return raw;
	endfunction

	assign joy_in    = '{joystick_0, joystick_1, joystick_2, joystick_3};
	assign analog_in = '{joystick_analog_0, joystick_analog_1,
		joystick_analog_2, joystick_analog_3};
	assign paddle_in = '{paddle_0, paddle_1, paddle_2, paddle_3};

	always_ff @(posedge clk_sys) begin
		joy_q <= joy_in;
	end

	//==========================================================================
	// Mouse packet
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		// Previous toggle bit for change detection
		mouse_toggle_q <= ps2_mouse[24];
		mouse_dx_q     <= clamp_step(ps2_mouse[4], ps2_mouse[15:9]);
		mouse_dy_q     <= clamp_step(ps2_mouse[5], ps2_mouse[23:17]);
		mouse_btn_q    <= ps2_mouse[1:0];
		if (reset) begin
			mouse_stb_q <= 1'b0;
		end else begin
			mouse_stb_q <= ps2_mouse[24] ^ mouse_toggle_q;
		end
	end

	//==========================================================================
	// Per-channel split
	//==========================================================================
	for (genvar i = 0; i < `PADDLE_PORTS; i++) begin : gen_ch
		always_ff @(posedge clk_sys) begin
			ch[i].stick_btn  <= joy_in[i][joy_bit_stick];
			ch[i].paddle_btn <= joy_in[i][joy_bit_paddle];
			ch[i].joy_a      <= analog_in[i];
			ch[i].paddle     <= paddle_in[i];
		end

		if (i == 0) begin : gen_mouse
			assign ch[i].mouse_stb = mouse_stb_q;
			assign ch[i].mouse_dx  = mouse_dx_q;
			assign ch[i].mouse_dy  = mouse_dy_q;
			assign ch[i].mouse_btn = mouse_btn_q;
		end else begin : gen_no_mouse
			assign ch[i].mouse_stb = 1'b0;
			assign ch[i].mouse_dx  = '0;
			assign ch[i].mouse_dy  = '0;
			assign ch[i].mouse_btn = '0;
		end
	end

endmodule

//--- paddle_channel/paddle_channel.sv
//==========================================================================
// One paddle channel. Picks paddle knob, analog stick or mouse as the
// source and one axis of it. The source and the mouse position settle
// one cycle after the inputs, and the pot and button one cycle later.
// Mouse positions saturate at -128 and 127.
//==========================================================================
`timescale 1ns/1ps
`include "atari_input_params.svh"

module paddle_channel (
	input  logic                  clk_sys,
	input  logic                  reset,
	paddle_in_if.dst              ch,
	input  logic                  invert_paddle,
	output atari_input_pkg::pot_t pot,
	output logic                  pot_btn
);
	import atari_input_pkg::*;

	localparam mouse_pos_t pos_max = 9'sd127;
	localparam mouse_pos_t pos_min = -9'sd128;

	pot_source_e src;
	logic        sel_y;
	mouse_pos_t  pos_x;
	mouse_pos_t  pos_y;
	logic        stick_x_hit;
	logic        stick_y_hit;
	pot_t        pre_pot;
	logic        pre_btn;

	function automatic mouse_pos_t saturate(input mouse_pos_t pos, input mouse_delta_t delta);
		mouse_pos_t sum;
		// Nine bits hold any position plus one clamped step
		sum = pos + delta;
		if (sum > pos_max)
			return pos_max;
		if (sum < pos_min)
			return pos_min;
		return sum;
	endfunction

	// Positive deflection past the threshold on either axis
	assign stick_x_hit = !ch.joy_a[7] && (ch.joy_a[7:0] > `STICK_THRESHOLD);
	assign stick_y_hit = !ch.joy_a[15] && (ch.joy_a[15:8] > `STICK_THRESHOLD);

	//==========================================================================
	// Source FSM, axis select and mouse position
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			src   <= pot_src_paddle;
			sel_y <= 1'b0;
			pos_x <= '0;
			pos_y <= '0;
		end else begin
			if (ch.mouse_stb) begin
				src   <= pot_src_mouse;
				pos_x <= saturate(pos_x, ch.mouse_dx);
				pos_y <= saturate(pos_y, ch.mouse_dy);
			end
			if (ch.stick_btn)
				src <= pot_src_stick;
			// Paddle button wins over everything else
			if (ch.paddle_btn)
				src <= pot_src_paddle;

			case (src)
				pot_src_mouse: begin
					if (ch.mouse_btn[0])
						sel_y <= 1'b1;
					else if (ch.mouse_btn[1])
						sel_y <= 1'b0;
				end
				pot_src_stick: begin
					if (stick_y_hit)
						sel_y <= 1'b1;
					else if (stick_x_hit)
						sel_y <= 1'b0;
				end
				default: begin
					sel_y <= sel_y;
				end
			endcase
		end
	end

	//==========================================================================
	// Pot value, two register stages
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		case (src)
			pot_src_stick: pre_pot <= sel_y ? ch.joy_a[15:8] : ch.joy_a[7:0];
			pot_src_mouse: pre_pot <= sel_y ? pos_y[7:0] : pos_x[7:0];
			// Knob is centred on 0x80
			default:       pre_pot <= {~ch.paddle[7], ch.paddle[6:0]};
		endcase
		pot <= invert_paddle ? ~pre_pot : pre_pot;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pre_btn <= 1'b0;
			pot_btn <= 1'b0;
		end else begin
			case (src)
				pot_src_stick: pre_btn <= ch.stick_btn;
				pot_src_mouse: pre_btn <= |ch.mouse_btn;
				default:       pre_btn <= ch.paddle_btn;
			endcase
			pot_btn <= pre_btn;
		end
	end

endmodule

//--- hdl/console_port_mux.sv
//==========================================================================
// Console side of the front end. Applies the player swap and drives the
// active-low player inputs one cycle after its inputs. Pause toggles
// on each press of any controller's pause button, seen through a
// two-stage synchroniser.
//==========================================================================
`timescale 1ns/1ps
`include "atari_input_params.svh"

module console_port_mux (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       swap_players,
	input  atari_input_pkg::joy_word_t joy_q [`PADDLE_PORTS],
	input  atari_input_pkg::pot_t      pot_in [`PADDLE_PORTS],
	input  logic                       pot_btn_in [`PADDLE_PORTS],
	output logic [3:0]                 p1_dir_n,
	output logic [3:0]                 p2_dir_n,
	output logic                       p1_fire_n,
	output logic                       p1_fire2_n,
	output logic                       p2_fire_n,
	output logic                       p2_fire2_n,
	output atari_input_pkg::pot_t      pot_1,
	output atari_input_pkg::pot_t      pot_2,
	output atari_input_pkg::pot_t      pot_3,
	output atari_input_pkg::pot_t      pot_4,
	output logic [`PADDLE_PORTS-1:0]   pot_btn_n,
	output logic                       start_n,
	output logic                       select_n,
	output logic                       pause
);
	import atari_input_pkg::*;

	joy_word_t                p1_joy;
	joy_word_t                p2_joy;
	pot_t                     pot_sw [`PADDLE_PORTS];
	logic [`PADDLE_PORTS-1:0] btn_sw;
	logic                     start_any;
	logic                     select_any;
	logic                     pause_any;
	logic [1:0]               pause_sync;
	logic                     pause_prev;

	assign p1_joy = swap_players ? joy_q[1] : joy_q[0];
	assign p2_joy = swap_players ? joy_q[0] : joy_q[1];

	// Swap exchanges pots in pairs, 1 with 2 and 3 with 4
	always_comb begin
		start_any  = 1'b0;
		select_any = 1'b0;
		pause_any  = 1'b0;
		for (int i = 0; i < `PADDLE_PORTS; i++) begin
			pot_sw[i]  = swap_players ? pot_in[i ^ 1] : pot_in[i];
			btn_sw[i]  = swap_players ? pot_btn_in[i ^ 1] : pot_btn_in[i];
			start_any  = start_any | joy_q[i][joy_bit_start];
			select_any = select_any | joy_q[i][joy_bit_select];
			pause_any  = pause_any | joy_q[i][joy_bit_pause];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			p1_dir_n   <= '1;
			p2_dir_n   <= '1;
			p1_fire_n  <= 1'b1;
			p1_fire2_n <= 1'b1;
			p2_fire_n  <= 1'b1;
			p2_fire2_n <= 1'b1;
			pot_btn_n  <= '1;
			start_n    <= 1'b1;
			select_n   <= 1'b1;
		end else begin
			p1_dir_n   <= ~p1_joy[3:0];
			p2_dir_n   <= ~p2_joy[3:0];
			p1_fire_n  <= ~p1_joy[joy_bit_fire];
			p1_fire2_n <= ~p1_joy[joy_bit_fire2];
			p2_fire_n  <= ~p2_joy[joy_bit_fire];
			p2_fire2_n <= ~p2_joy[joy_bit_fire2];
			pot_btn_n  <= ~btn_sw;
			start_n    <= ~start_any;
			select_n   <= ~select_any;
		end
	end

	always_ff @(posedge clk_sys) begin
		pot_1 <= pot_sw[0];
		pot_2 <= pot_sw[1];
		pot_3 <= pot_sw[2];
		pot_4 <= pot_sw[3];
	end

	//==========================================================================
	// Pause toggle
	//==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pause_sync <= '0;
			pause_prev <= 1'b0;
			pause      <= 1'b0;
		end else begin
			pause_sync <= {pause_sync[0], pause_any};
			pause_prev <= pause_sync[1];
			// Rising edge only, a held button toggles once
			if (pause_sync[1] && !pause_prev)
				pause <= ~pause;
		end
	end

endmodule

//--- hdl/atari_input_top.sv
//==========================================================================
// Controller front end top level. Four host controllers and one mouse
// in, console player inputs out. Pots trail the host inputs by four
// cycles and directions by two. Only pot 1 can follow the mouse.
//==========================================================================
`timescale 1ns/1ps
`include "atari_input_params.svh"

module atari_input_top (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  atari_input_pkg::joy_word_t    joystick_0,
	input  atari_input_pkg::joy_word_t    joystick_1,
	input  atari_input_pkg::joy_word_t    joystick_2,
	input  atari_input_pkg::joy_word_t    joystick_3,
	input  atari_input_pkg::analog_word_t joystick_analog_0,
	input  atari_input_pkg::analog_word_t joystick_analog_1,
	input  atari_input_pkg::analog_word_t joystick_analog_2,
	input  atari_input_pkg::analog_word_t joystick_analog_3,
	input  atari_input_pkg::pot_t         paddle_0,
	input  atari_input_pkg::pot_t         paddle_1,
	input  atari_input_pkg::pot_t         paddle_2,
	input  atari_input_pkg::pot_t         paddle_3,
	input  atari_input_pkg::mouse_pkt_t   ps2_mouse,
	input  logic                          swap_players,
	input  logic                          invert_paddle,
	output logic [3:0]                    p1_dir_n,
	output logic [3:0]                    p2_dir_n,
	output logic                          p1_fire_n,
	output logic                          p1_fire2_n,
	output logic                          p2_fire_n,
	output logic                          p2_fire2_n,
	output atari_input_pkg::pot_t         pot_1,
	output atari_input_pkg::pot_t         pot_2,
	output atari_input_pkg::pot_t         pot_3,
	output atari_input_pkg::pot_t         pot_4,
	output logic [`PADDLE_PORTS-1:0]      pot_btn_n,
	output logic                          start_n,
	output logic                          select_n,
	output logic                          pause
);
	import atari_input_pkg::*;

	paddle_in_if ch_if [`PADDLE_PORTS] ();

	joy_word_t joy_q [`PADDLE_PORTS];
	pot_t      pot_w [`PADDLE_PORTS];
	logic      pot_btn_w [`PADDLE_PORTS];

	host_input_decode host_input_decode_inst (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.joystick_0        (joystick_0),
		.joystick_1        (joystick_1),
		.joystick_2        (joystick_2),
		.joystick_3        (joystick_3),
		.joystick_analog_0 (joystick_analog_0),
		.joystick_analog_1 (joystick_analog_1),
		.joystick_analog_2 (joystick_analog_2),
		.joystick_analog_3 (joystick_analog_3),
		.paddle_0          (paddle_0),
		.paddle_1          (paddle_1),
		.paddle_2          (paddle_2),
		.paddle_3          (paddle_3),
		.ps2_mouse         (ps2_mouse),
		.ch                (ch_if),
		.joy_q             (joy_q)
	);

	for (genvar i = 0; i < `PADDLE_PORTS; i++) begin : gen_paddle
		paddle_channel paddle_channel_inst (
			.clk_sys       (clk_sys),
			.reset         (reset),
			.ch            (ch_if[i]),
			.invert_paddle (invert_paddle),
			.pot           (pot_w[i]),
			.pot_btn       (pot_btn_w[i])
		);
	end

	console_port_mux console_port_mux_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.swap_players (swap_players),
		.joy_q        (joy_q),
		.pot_in       (pot_w),
		.pot_btn_in   (pot_btn_w),
		.p1_dir_n     (p1_dir_n),
		.p2_dir_n     (p2_dir_n),
		.p1_fire_n    (p1_fire_n),
		.p1_fire2_n   (p1_fire2_n),
		.p2_fire_n    (p2_fire_n),
		.p2_fire2_n   (p2_fire2_n),
		.pot_1        (pot_1),
		.pot_2        (pot_2),
		.pot_3        (pot_3),
		.pot_4        (pot_4),
		.pot_btn_n    (pot_btn_n),
		.start_n      (start_n),
		.select_n     (select_n),
		.pause        (pause)
	);

endmodule

//--- testbench/atari_input_sva.sv
//==========================================================================
// Output rules of the front end, bound into the top level. The history
// registers cover the register stages between a host input and the
// console outputs.
//==========================================================================
`timescale 1ns/1ps

module atari_input_sva (
	input logic                          clk_sys,
	input logic                          reset,
	input atari_input_pkg::joy_word_t    joystick_0,
	input atari_input_pkg::joy_word_t    joystick_1,
	input atari_input_pkg::joy_word_t    joystick_2,
	input atari_input_pkg::joy_word_t    joystick_3,
	input atari_input_pkg::mouse_pkt_t   ps2_mouse,
	input logic [3:0]                    p1_dir_n,
	input logic [3:0]                    p2_dir_n,
	input logic                          p1_fire_n,
	input logic                          p1_fire2_n,
	input logic                          p2_fire_n,
	input logic                          p2_fire2_n,
	input logic [3:0]                    pot_btn_n,
	input logic                          start_n,
	input logic                          select_n,
	input logic                          pause
);
	import atari_input_pkg::*;

	logic       pause_in;
	logic       pause_in_q;
	logic [4:0] rise_hist;
	logic       start_in;
	logic       btn_in;
	logic [5:0] btn_hist;

	assign pause_in = joystick_0[joy_bit_pause] | joystick_1[joy_bit_pause]
		| joystick_2[joy_bit_pause] | joystick_3[joy_bit_pause];
	assign start_in = joystick_0[joy_bit_start] | joystick_1[joy_bit_start]
		| joystick_2[joy_bit_start] | joystick_3[joy_bit_start];
	// Any stick, paddle or mouse button
	assign btn_in = |{joystick_0[6:5], joystick_1[6:5], joystick_2[6:5],
		joystick_3[6:5], ps2_mouse[1:0]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pause_in_q <= 1'b0;
			rise_hist  <= '0;
			btn_hist   <= '1;
		end else begin
			pause_in_q <= pause_in;
			rise_hist  <= {rise_hist[3:0], pause_in & !pause_in_q};
			btn_hist   <= {btn_hist[4:0], btn_in};
		end
	end

	pause_after_press: assert property (@(posedge clk_sys) disable iff (reset)
		(pause != $past(pause)) |-> ($past(reset) || (|rise_hist)))
		else $error("pause changed with no recent pause press");

	idle_in_reset: assert property (@(posedge clk_sys)
		reset |=> (p1_dir_n == 4'hF && p2_dir_n == 4'hF && p1_fire_n && p1_fire2_n
			&& p2_fire_n && p2_fire2_n && pot_btn_n == 4'hF && start_n && select_n))
		else $error("active-low output not idle during reset");

	btn_released: assert property (@(posedge clk_sys) disable iff (reset)
		(!btn_in && btn_hist == '0) |-> (pot_btn_n == 4'hF))
		else $error("pot button active with no button pressed");

	start_follows: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(reset) |-> (start_n == !$past(start_in, 2)))
		else $error("start_n does not follow the start buttons");

endmodule

bind atari_input_top atari_input_sva atari_input_sva_inst (.*);

//--- testbench/atari_input_tb.sv
//==========================================================================
// Directed testbench for the controller front end. Stimulus changes on
// the rising edge, and results are sampled on the falling edge eight
// cycles later, beyond the four-cycle pot latency. Expected pot values
// come from a behavioural model of the source, clamp and invert rules.
//==========================================================================
`timescale 1ns/1ps
`include "atari_input_params.svh"

module atari_input_tb;
	import atari_input_pkg::*;

	logic         clk_sys;
	logic         reset;
	joy_word_t    joy [`PADDLE_PORTS];
	analog_word_t analog [`PADDLE_PORTS];
	pot_t         paddle [`PADDLE_PORTS];
	mouse_pkt_t   ps2_mouse;
	logic         swap_players;
	logic         invert_paddle;
	logic [3:0]   p1_dir_n;
	logic [3:0]   p2_dir_n;
	logic         p1_fire_n;
	logic         p1_fire2_n;
	logic         p2_fire_n;
	logic         p2_fire2_n;
	pot_t         pot_out [`PADDLE_PORTS];
	logic [3:0]   pot_btn_n;
	logic         start_n;
	logic         select_n;
	logic         pause;
	int           checks;
	int           errors;

	atari_input_top atari_input_top_inst (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.joystick_0        (joy[0]),
		.joystick_1        (joy[1]),
		.joystick_2        (joy[2]),
		.joystick_3        (joy[3]),
		.joystick_analog_0 (analog[0]),
		.joystick_analog_1 (analog[1]),
		.joystick_analog_2 (analog[2]),
		.joystick_analog_3 (analog[3]),
		.paddle_0          (paddle[0]),
		.paddle_1          (paddle[1]),
		.paddle_2          (paddle[2]),
		.paddle_3          (paddle[3]),
		.ps2_mouse         (ps2_mouse),
		.swap_players      (swap_players),
		.invert_paddle     (invert_paddle),
		.p1_dir_n          (p1_dir_n),
		.p2_dir_n          (p2_dir_n),
		.p1_fire_n         (p1_fire_n),
		.p1_fire2_n        (p1_fire2_n),
		.p2_fire_n         (p2_fire_n),
		.p2_fire2_n        (p2_fire2_n),
		.pot_1             (pot_out[0]),
		.pot_2             (pot_out[1]),
		.pot_3             (pot_out[2]),
		.pot_4             (pot_out[3]),
		.pot_btn_n         (pot_btn_n),
		.start_n           (start_n),
		.select_n          (select_n),
		.pause             (pause)
	);

	always #20 clk_sys = ~clk_sys;

	//==========================================================================
	// Compare tasks and helpers
	//==========================================================================
	task automatic check_pot(input string name, input pot_t got, input pot_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic check_dir(input string name, input logic [3:0] got,
		input logic [3:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s got %h expected %h", name, got, expected);
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk_sys);
	endtask

	// Eight cycles after the last stimulus, then sample mid-cycle
	task automatic settle();
		wait_cycles(8);
		@(negedge clk_sys);
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset <= 1'b1;
		wait_cycles(5);
		reset <= 1'b0;
	endtask

	task automatic wait_pause(input logic expected);
		int n;
		checks++;
		for (n = 0; n < 8 && pause !== expected; n++)
			@(negedge clk_sys);
		if (pause !== expected) begin
			errors++;
			$display("pause did not change to %0b within 8 cycles of the press", expected);
		end
	endtask

	// Knob reading is centred by flipping the top bit
	function automatic pot_t knob_value(input pot_t raw, input logic inv);
		pot_t centred;
		centred = raw + 8'h80;
		return inv ? 8'hFF - centred : centred;
	endfunction

	function automatic int accumulate(input int pos, input int delta);
		int step;
		int sum;
		step = (delta > `MOUSE_STEP_MAX) ? `MOUSE_STEP_MAX : delta;
		step = (step < -`MOUSE_STEP_MAX) ? -`MOUSE_STEP_MAX : step;
		sum = pos + step;
		if (sum > 127)
			sum = 127;
		if (sum < -128)
			sum = -128;
		return sum;
	endfunction

	task automatic send_packet(input int dx, input int dy, input logic [1:0] btn);
		logic [7:0] bx;
		logic [7:0] by;
		bx = 8'(dx);
		by = 8'(dy);
		@(posedge clk_sys);
		ps2_mouse <= {~ps2_mouse[24], by[6:0], 1'b0, bx[6:0], 3'b000,
			by[7], bx[7], 2'b00, btn};
	endtask

	//==========================================================================
	// Directed tests
	//==========================================================================
	task automatic test_directions();
		joy_word_t j0;
		joy_word_t j1;
		joy_word_t pa;
		joy_word_t pb;
		for (int n = 0; n < 8; n++) begin
			// Directions, fire and fire 2 only
			j0 = joy_word_t'($urandom) & 16'h041F;
			j1 = joy_word_t'($urandom) & 16'h041F;
			pa = n[0] ? j1 : j0;
			pb = n[0] ? j0 : j1;
			@(posedge clk_sys);
			joy[0] <= j0;
			joy[1] <= j1;
			swap_players <= n[0];
			settle();
			check_dir("p1_dir_n", p1_dir_n, ~pa[3:0]);
			check_dir("p2_dir_n", p2_dir_n, ~pb[3:0]);
			check_bit("p1_fire_n", p1_fire_n, ~pa[4]);
			check_bit("p1_fire2_n", p1_fire2_n, ~pa[10]);
			check_bit("p2_fire_n", p2_fire_n, ~pb[4]);
			check_bit("p2_fire2_n", p2_fire2_n, ~pb[10]);
		end
		@(posedge clk_sys);
		joy[0] <= '0;
		joy[1] <= '0;
		swap_players <= 1'b0;
	endtask

	task automatic test_paddle();
		pot_t raw [`PADDLE_PORTS];
		int   src;
		for (int n = 0; n < 4; n++) begin
			@(posedge clk_sys);
			for (int k = 0; k < `PADDLE_PORTS; k++) begin
				raw[k] = pot_t'($urandom);
				paddle[k] <= raw[k];
				joy[k] <= 16'h0040;
			end
			invert_paddle <= n[0];
			swap_players <= n[1];
			settle();
			for (int k = 0; k < `PADDLE_PORTS; k++) begin
				src = n[1] ? (k ^ 1) : k;
				check_pot($sformatf("pot_%0d", k + 1), pot_out[k], knob_value(raw[src], n[0]));
			end
			check_dir("pot_btn_n", pot_btn_n, 4'h0);
			// Buttons held on controllers 0 and 2 only
			@(posedge clk_sys);
			joy[1] <= '0;
			joy[3] <= '0;
			settle();
			check_dir("pot_btn_n", pot_btn_n, n[1] ? 4'b0101 : 4'b1010);
		end
		@(posedge clk_sys);
		joy <= '{default: '0};
		invert_paddle <= 1'b0;
		swap_players <= 1'b0;
		settle();
		check_dir("pot_btn_n", pot_btn_n, 4'hF);
	endtask

	task automatic test_stick();
		analog_word_t a [`PADDLE_PORTS];
		@(posedge clk_sys);
		for (int k = 0; k < `PADDLE_PORTS; k++) begin
			// X past the threshold, Y below it
			a[k] = {8'($urandom % 100), 8'(101 + $urandom % 27)};
			analog[k] <= a[k];
			joy[k] <= 16'h0020;
		end
		@(posedge clk_sys);
		joy <= '{default: '0};
		settle();
		for (int k = 0; k < `PADDLE_PORTS; k++)
			check_pot($sformatf("pot_%0d", k + 1), pot_out[k], a[k][7:0]);
		@(posedge clk_sys);
		for (int k = 0; k < `PADDLE_PORTS; k++) begin
			a[k][15:8] = 8'(101 + $urandom % 27);
			analog[k] <= a[k];
		end
		settle();
		for (int k = 0; k < `PADDLE_PORTS; k++)
			check_pot($sformatf("pot_%0d", k + 1), pot_out[k], a[k][15:8]);
		// Y back under the threshold hands the pot to X again
		@(posedge clk_sys);
		for (int k = 0; k < `PADDLE_PORTS; k++) begin
			a[k][15:8] = 8'($urandom % 100);
			analog[k] <= a[k];
		end
		settle();
		for (int k = 0; k < `PADDLE_PORTS; k++)
			check_pot($sformatf("pot_%0d", k + 1), pot_out[k], a[k][7:0]);
	endtask

	task automatic test_mouse();
		int pos_x;
		int pos_y;
		int dx;
		int dy;
		apply_reset();
		pos_x = 0;
		pos_y = 0;
		// Back-to-back packets, saturating high, stepping back, saturating low
		for (int n = 0; n < 51; n++) begin
			if (n < 16) begin
				dx = 25;
				dy = -4;
			end else if (n < 21) begin
				dx = -3;
				dy = 9;
			end else begin
				dx = -100;
				dy = 6;
			end
			send_packet(dx, dy, 2'b00);
			pos_x = accumulate(pos_x, dx);
			pos_y = accumulate(pos_y, dy);
			if (n == 15 || n == 20 || n == 50) begin
				settle();
				check_pot("pot_1", pot_out[0], pot_t'(pos_x));
			end
		end
		// Left button moves pot 1 over to the Y position
		send_packet(0, 0, 2'b01);
		settle();
		check_pot("pot_1", pot_out[0], pot_t'(pos_y));
		for (int k = 1; k < `PADDLE_PORTS; k++)
			check_pot($sformatf("pot_%0d", k + 1), pot_out[k], knob_value(paddle[k], 1'b0));
	endtask

	task automatic test_switches();
		apply_reset();
		@(posedge clk_sys);
		joy[2] <= 16'h0080;
		settle();
		check_bit("start_n", start_n, 1'b0);
		check_bit("select_n", select_n, 1'b1);
		@(posedge clk_sys);
		joy[2] <= '0;
		joy[3] <= 16'h0100;
		settle();
		check_bit("start_n", start_n, 1'b1);
		check_bit("select_n", select_n, 1'b0);
		@(posedge clk_sys);
		joy[3] <= '0;
		settle();
		check_bit("select_n", select_n, 1'b1);
		check_bit("pause", pause, 1'b0);

		@(posedge clk_sys);
		joy[1] <= 16'h0200;
		wait_pause(1'b1);
		// Holding the button must not toggle again
		settle();
		check_bit("pause", pause, 1'b1);
		@(posedge clk_sys);
		joy[1] <= '0;
		settle();
		check_bit("pause", pause, 1'b1);
		@(posedge clk_sys);
		joy[3] <= 16'h0200;
		wait_pause(1'b0);
		@(posedge clk_sys);
		joy[3] <= '0;
		settle();
		@(posedge clk_sys);
		joy[0] <= 16'h0200;
		wait_pause(1'b1);
		@(posedge clk_sys);
		joy[0] <= '0;
		settle();
		apply_reset();
		@(negedge clk_sys);
		check_bit("pause", pause, 1'b0);
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================
	initial begin
		void'($urandom(32'h5bb5_512d));
		checks = 0;
		errors = 0;
		clk_sys = 1'b0;
		reset = 1'b1;
		joy = '{default: '0};
		analog = '{default: '0};
		paddle = '{default: '0};
		ps2_mouse = '0;
		swap_players = 1'b0;
		invert_paddle = 1'b0;
		wait_cycles(5);
		reset <= 1'b0;

		test_directions();
		test_paddle();
		test_stick();
		test_mouse();
		test_switches();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- atari_input_top.f
+incdir+common
common/atari_input_pkg.sv
common/paddle_in_if.sv
hdl/host_input_decode.sv
paddle_channel/paddle_channel.sv
hdl/console_port_mux.sv
hdl/atari_input_top.sv
testbench/atari_input_sva.sv
testbench/atari_input_tb.sv

//--- Makefile
# Verilator build and run of the controller front end testbench

VERILATOR ?= verilator
TOP       ?= atari_input_tb
FILELIST  ?= atari_input_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the simulation output holds the pass message
run: compile
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
